// File: Makefile
# Verilator build and run of the rv_core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(wildcard design/*.sv design/*.svh dv/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: design/rv_alu.sv
module rv_alu (
    input  rv_core_pkg::alu_op_t op_i,
    input  rv_core_pkg::xlen_t   a_i,
    input  rv_core_pkg::xlen_t   b_i,
    output rv_core_pkg::xlen_t   result_o
);
    import rv_core_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = xlen_t'(lt_s);
            ALU_SLTU:   result_o = xlen_t'(lt_u);
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:    result_o = xlen_t'($signed(a_i) >>> shamt);
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

// File: design/rv_core.sv
`include "rv_core_cfg.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid_i,
    input  rv_core_pkg::inst_t    inst_i,
    output logic                  retire_valid_o,
    output logic                  retire_rd_we_o,
    output rv_core_pkg::rf_addr_t retire_rd_o,
    output rv_core_pkg::xlen_t    retire_data_o
);
    import rv_core_pkg::*;

    // --------------------------------------------------
    // reset sequence
    logic [`RV_RST_SEQ_LEN-1:0] rst_seq;
    logic                       flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            rst_seq <= '1;
        end else begin
            rst_seq <= {rst_seq[`RV_RST_SEQ_LEN-2:0], 1'b0};
        end
    end

    // top bit drops last
    assign flush = rst_seq[`RV_RST_SEQ_LEN-1];

    // --------------------------------------------------
    // decode
    dec_ctrl_t  dec_ctrl;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    exe_stage_t exe_d;
    exe_stage_t exe_q;
    wb_t        wb_d;
    wb_t        wb_q;
    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      alu_result;

    rv_decoder u_decoder (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .ctrl_o       (dec_ctrl)
    );

    rv_reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .we_i      (wb_q.valid && wb_q.rd_we),
        .waddr_i   (wb_q.rd),
        .wdata_i   (wb_q.data),
        .raddr_a_i (dec_ctrl.rs1),
        .raddr_b_i (dec_ctrl.rs2),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data)
    );

    always_comb begin
        exe_d             = '{ctrl: dec_ctrl, rs1_data: rs1_data, rs2_data: rs2_data};
        exe_d.ctrl.valid  = dec_ctrl.valid && !flush;
        exe_d.ctrl.rd_we  = dec_ctrl.rd_we && !flush;
    end

    // decode/execute stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            exe_q.ctrl.valid <= 1'b0;
            exe_q.ctrl.rd_we <= 1'b0;
        end else begin
            exe_q <= exe_d;
        end
    end

    // --------------------------------------------------
    // execute
    rv_operand_fwd u_operand_fwd (
        .exe_i  (exe_q),
        .wb_i   (wb_q),
        .op_a_o (op_a),
        .op_b_o (op_b)
    );

    rv_alu u_alu (
        .op_i     (exe_q.ctrl.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result)
    );

    assign wb_d.valid = exe_q.ctrl.valid && !flush;
    assign wb_d.rd_we = exe_q.ctrl.valid && exe_q.ctrl.rd_we && !flush;
    assign wb_d.rd    = exe_q.ctrl.rd;
    assign wb_d.data  = alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q.valid <= 1'b0;
            wb_q.rd_we <= 1'b0;
        end else begin
            wb_q <= wb_d;
        end
    end

    // --------------------------------------------------
    // writeback and retire
    assign retire_valid_o = wb_q.valid;
    assign retire_rd_we_o = wb_q.rd_we;
    assign retire_rd_o    = wb_q.rd;
    assign retire_data_o  = wb_q.data;

endmodule

// File: design/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath and register file sizes
`define RV_XLEN         32
`define RV_RF_ADDR_W    5
`define RV_RF_REGS      32

// stage valids held low this many cycles after reset
`define RV_RST_SEQ_LEN  3

// major opcodes of the supported groups
`define RV_OPC_OP       7'b0110011
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_LUI      7'b0110111

`endif

// File: design/rv_core_pkg.sv
`include "rv_core_cfg.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]      xlen_t;
    typedef logic [31:0]              inst_t;
    typedef logic [`RV_RF_ADDR_W-1:0] rf_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // lui result passes straight through
        ALU_PASS_B
    } alu_op_t;

    // decode control
    typedef struct packed {
        logic     valid;
        logic     rd_we;
        rf_addr_t rd;
        rf_addr_t rs1;
        rf_addr_t rs2;
        logic     use_imm;
        alu_op_t  alu_op;
        xlen_t    imm;
    } dec_ctrl_t;

    // decode/execute register
    typedef struct packed {
        dec_ctrl_t ctrl;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
    } exe_stage_t;

    typedef struct packed {
        logic     valid;
        logic     rd_we;
        rf_addr_t rd;
        xlen_t    data;
    } wb_t;

endpackage

// File: design/rv_decoder.sv
`include "rv_core_cfg.svh"

module rv_decoder (
    input  logic                   inst_valid_i,
    input  rv_core_pkg::inst_t     inst_i,
    output rv_core_pkg::dec_ctrl_t ctrl_o
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rf_addr_t   rd;
    logic       alt;
    logic       shift;
    logic       legal;
    logic       valid;
    alu_op_t    base_op;
    alu_op_t    op;
    logic       use_imm;
    xlen_t      imm;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // funct7 of sub and sra
    assign alt   = (funct7 == 7'b0100000);
    assign shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    // funct3 map shared by both integer groups
    always_comb begin
        case (funct3)
            3'b000:  base_op = ALU_ADD;
            3'b001:  base_op = ALU_SLL;
            3'b010:  base_op = ALU_SLT;
            3'b011:  base_op = ALU_SLTU;
            3'b100:  base_op = ALU_XOR;
            3'b101:  base_op = ALU_SRL;
            3'b110:  base_op = ALU_OR;
            default: base_op = ALU_AND;
        endcase
    end

    always_comb begin
        legal   = 1'b0;
        op      = base_op;
        use_imm = 1'b0;
        imm     = '0;
        case (opcode)
            `RV_OPC_OP: begin
                legal = (funct7 == 7'b0) ||
                        (alt && ((funct3 == 3'b000) || (funct3 == 3'b101)));
                if (alt) begin
                    op = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
                end
            end
            `RV_OPC_OP_IMM: begin
                // upper imm bits only matter for the shifts
                legal   = !shift || (funct7 == 7'b0) || (alt && (funct3 == 3'b101));
                use_imm = 1'b1;
                imm     = {{20{inst_i[31]}}, inst_i[31:20]};
                if (shift && alt) begin
                    op = ALU_SRA;
                end
            end
            `RV_OPC_LUI: begin
                legal   = 1'b1;
                op      = ALU_PASS_B;
                use_imm = 1'b1;
                imm     = {inst_i[31:12], 12'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    assign valid = inst_valid_i && legal;

    always_comb begin
        ctrl_o.valid   = valid;
        ctrl_o.rd_we   = valid && (rd != '0);
        ctrl_o.rd      = rd;
        ctrl_o.rs1     = inst_i[19:15];
        ctrl_o.rs2     = inst_i[24:20];
        ctrl_o.use_imm = use_imm;
        ctrl_o.alu_op  = op;
        ctrl_o.imm     = imm;
    end

endmodule

// File: design/rv_operand_fwd.sv
module rv_operand_fwd (
    input  rv_core_pkg::exe_stage_t exe_i,
    input  rv_core_pkg::wb_t        wb_i,
    output rv_core_pkg::xlen_t      op_a_o,
    output rv_core_pkg::xlen_t      op_b_o
);
    import rv_core_pkg::*;

    logic  wb_writes;
    logic  fwd_a;
    logic  fwd_b;
    xlen_t rs2_val;

    // writeback holds the result of the previous instruction
    assign wb_writes = wb_i.valid && wb_i.rd_we && (wb_i.rd != '0);

    assign fwd_a = wb_writes && (wb_i.rd == exe_i.ctrl.rs1);
    assign fwd_b = wb_writes && (wb_i.rd == exe_i.ctrl.rs2);

    assign op_a_o  = fwd_a ? wb_i.data : exe_i.rs1_data;
    assign rs2_val = fwd_b ? wb_i.data : exe_i.rs2_data;

    // for the immediate forms shamt sits in the low imm bits
    assign op_b_o = exe_i.ctrl.use_imm ? exe_i.ctrl.imm : rs2_val;

endmodule

// File: design/rv_reg_file.sv
`include "rv_core_cfg.svh"

module rv_reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we_i,
    input  rv_core_pkg::rf_addr_t waddr_i,
    input  rv_core_pkg::xlen_t    wdata_i,
    input  rv_core_pkg::rf_addr_t raddr_a_i,
    input  rv_core_pkg::rf_addr_t raddr_b_i,
    output rv_core_pkg::xlen_t    rdata_a_o,
    output rv_core_pkg::xlen_t    rdata_b_o
);
    import rv_core_pkg::*;

    // x0 has no storage
    xlen_t regs [`RV_RF_REGS-1:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_RF_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through makes a same-cycle write visible to decode
    assign rdata_a_o = (raddr_a_i == '0)                ? '0      :
                       (we_i && (raddr_a_i == waddr_i)) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0)                ? '0      :
                       (we_i && (raddr_b_i == waddr_i)) ? wdata_i : regs[raddr_b_i];

endmodule

// File: dv/rv_core_tb.sv
`include "rv_core_cfg.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    typedef struct packed {
        logic     rd_we;
        rf_addr_t rd;
        xlen_t    data;
        int       due;
    } retire_t;

    logic     clk;
    logic     rst;
    logic     inst_valid;
    inst_t    inst;
    logic     retire_valid;
    logic     retire_rd_we;
    rf_addr_t retire_rd;
    xlen_t    retire_data;
    integer   seed;
    int       cyc;
    xlen_t    model_regs [`RV_RF_REGS];
    retire_t  exp_q [$];

    rv_core dut (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid),
        .inst_i         (inst),
        .retire_valid_o (retire_valid),
        .retire_rd_we_o (retire_rd_we),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic mismatch(input string field, input xlen_t got, input xlen_t exp);
        fail_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                           $time, field, got, exp));
    endtask

    // --------------------------------------------------
    // reference model
    function automatic logic is_supported(input inst_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            `RV_OPC_LUI:    return 1'b1;
            `RV_OPC_OP:     return (f7 == 7'h00) ||
                                   ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
            // only the shifts put limits on the upper immediate bits
            `RV_OPC_OP_IMM: return (f3 == 3'd1) ? (f7 == 7'h00) :
                                   (f3 == 3'd5) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;
            default:        return 1'b0;
        endcase
    endfunction

    function automatic xlen_t model_result(input inst_t w);
        xlen_t a;
        xlen_t b;
        a = model_regs[w[19:15]];
        b = (w[6:0] == `RV_OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        if (w[6:0] == `RV_OPC_LUI) begin
            return {w[31:12], 12'h000};
        end
        case (w[14:12])
            3'd0:    return (w[30] && (w[6:0] == `RV_OPC_OP)) ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return w[30] ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // --------------------------------------------------
    // stimulus
    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // x0..x7 only so that dependencies stay close together
    function automatic rf_addr_t rand_reg();
        return rf_addr_t'(rnd() & 32'd7);
    endfunction

    function automatic inst_t random_inst(input int kind);
        logic [31:0] w;
        logic [2:0]  f3;
        logic [6:0]  f7;
        w  = rnd();
        f3 = w[14:12];
        f7 = (w[30] && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
        case (kind)
            0: return {f7, rand_reg(), rand_reg(), f3, rand_reg(), `RV_OPC_OP};
            1: return {(f3 == 3'd1) || (f3 == 3'd5) ? {f7, w[24:20]} : w[31:20],
                       rand_reg(), f3, rand_reg(), `RV_OPC_OP_IMM};
            2: return {w[31:12], rand_reg(), `RV_OPC_LUI};
            default: begin
                while ((w[6:0] == `RV_OPC_OP) || (w[6:0] == `RV_OPC_OP_IMM) ||
                       (w[6:0] == `RV_OPC_LUI)) begin
                    w = rnd();
                end
                // some turn into register ops with the multiply funct7
                if (w[31]) begin
                    w[31:25] = 7'h01;
                    w[6:0]   = `RV_OPC_OP;
                end
                w[11:7] = rand_reg();
                return w;
            end
        endcase
    endfunction

    task automatic check_retire();
        retire_t e;
        assert ((exp_q.size() == 0) || (exp_q[0].due >= cyc))
            else fail_run("an issued instruction did not retire on time");
        if (retire_valid) begin
            assert (exp_q.size() > 0)
                else fail_run("a retirement arrived with no instruction outstanding");
            e = exp_q.pop_front();
            assert (e.due == cyc) else mismatch("retire cycle", xlen_t'(cyc), xlen_t'(e.due));
            assert (retire_rd == e.rd)
                else mismatch("retire_rd_o", xlen_t'(retire_rd), xlen_t'(e.rd));
            assert (retire_rd_we == e.rd_we)
                else mismatch("retire_rd_we_o", xlen_t'(retire_rd_we), xlen_t'(e.rd_we));
            assert (retire_data == e.data) else mismatch("retire_data_o", retire_data, e.data);
        end
    endtask

    task automatic issue_inst(input inst_t w);
        retire_t e;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        cyc++;
        if (is_supported(w)) begin
            e.rd    = w[11:7];
            e.rd_we = (w[11:7] != 5'd0);
            e.data  = model_result(w);
            e.due   = cyc + 2;
            exp_q.push_back(e);
            if (e.rd_we) begin
                model_regs[e.rd] = e.data;
            end
        end
        @(negedge clk);
        check_retire();
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= rnd();
        cyc++;
        @(negedge clk);
        check_retire();
    endtask

    // --------------------------------------------------
    initial begin
        int kind;
        int timeout;
        seed       = 27;
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        cyc        = 0;
        for (int i = 0; i < `RV_RF_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (5) idle_cycle();

        // add x0, xi, x9 reads every register of the cleared file
        issue_inst({20'(rnd()), 5'd9, `RV_OPC_LUI});
        for (int i = 1; i < `RV_RF_REGS; i++) begin
            issue_inst({7'h00, 5'd9, rf_addr_t'(i), 3'd0, 5'd0, `RV_OPC_OP});
        end

        // producer x5 then consumer at distance d on rs1 and then on rs2
        for (int d = 1; d <= 3; d++) begin
            for (int side = 0; side < 2; side++) begin
                issue_inst({20'(rnd()), 5'd5, `RV_OPC_LUI});
                repeat (d - 1) issue_inst({20'(rnd()), 5'd6, `RV_OPC_LUI});
                if (side == 0) issue_inst({7'h00, 5'd0, 5'd5, 3'd0, 5'd7, `RV_OPC_OP});
                else issue_inst({7'h20, 5'd5, 5'd0, 3'd0, 5'd7, `RV_OPC_OP});
            end
        end

        // addi x0, x5, 0x123 then add x7, x0, x0
        issue_inst({12'h123, 5'd5, 3'd0, 5'd0, `RV_OPC_OP_IMM});
        issue_inst({7'h00, 5'd0, 5'd0, 3'd0, 5'd7, `RV_OPC_OP});

        for (int n = 0; n < 3000; n++) begin
            kind = int'(rnd() & 32'd7);
            if (kind == 7) idle_cycle();
            else issue_inst(random_inst(kind % 4));
        end

        timeout = 0;
        while ((exp_q.size() > 0) && (timeout < 20)) begin
            idle_cycle();
            timeout++;
        end
        if (exp_q.size() > 0) begin
            fail_run("retirements stopped arriving during the final drain");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: rv_core.f
+incdir+design
design/rv_core_pkg.sv
design/rv_decoder.sv
design/rv_reg_file.sv
design/rv_operand_fwd.sv
design/rv_alu.sv
design/rv_core.sv
dv/rv_core_tb.sv
